// File: hdl/rv32i_types_pkg.sv
// RV32I instruction and ALU types
package rv32i_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes handled by the execution block
    typedef enum logic [6:0] {
        REGREG = 7'b0110011,
        IMMED  = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    // Shared by the register and immediate forms
    typedef enum logic [2:0] {
        ADDSUB = 3'b000,
        SLL    = 3'b001,
        SLT    = 3'b010,
        SLTU   = 3'b011,
        XOR    = 3'b100,
        SR     = 3'b101,
        OR     = 3'b110,
        AND    = 3'b111
    } funct3_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    typedef enum logic {
        W_SEL_FROM_ALU,
        W_SEL_FROM_IMM_U
    } w_sel_t;

endpackage

// File: hdl/apb_map_pkg.sv
// APB register map
package apb_map_pkg;

    typedef logic [11:0] apb_addr_t;

    // Register xN lives at REGS_BASE + 4*N
    localparam apb_addr_t REGS_BASE   = 12'h000;
    localparam apb_addr_t INSTR_ADDR  = 12'h080;
    localparam apb_addr_t PC_ADDR     = 12'h084;
    localparam apb_addr_t STATUS_ADDR = 12'h088;

    // Status word fields
    localparam int STATUS_ILLEGAL_BIT = 0;
    localparam int STATUS_COUNT_LSB   = 16;
    localparam int STATUS_COUNT_MSB   = 31;

    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_EXEC
    } issue_state_t;

endpackage

// File: hdl/control_unit.sv
// Instruction decode
`timescale 1ns/1ps

module control_unit #(
    parameter int NUM_REGS = 32
) (
    input  rv32i_types_pkg::instr_t   instr_i,
    output rv32i_types_pkg::reg_idx_t rs1_o,
    output rv32i_types_pkg::reg_idx_t rs2_o,
    output rv32i_types_pkg::reg_idx_t rd_o,
    output rv32i_types_pkg::word_t    imm_o,
    output logic                      alu_a_sel_o,
    output logic                      alu_b_sel_o,
    output rv32i_types_pkg::alu_op_t  alu_op_o,
    output rv32i_types_pkg::w_sel_t   w_sel_o,
    output logic                      wen_o,
    output logic                      illegal_o
);
    rv32i_types_pkg::opcode_t opcode;
    rv32i_types_pkg::funct3_t funct3;
    logic [6:0]               funct7;
    logic                     is_regreg;
    logic                     is_immed;
    logic                     sr;
    logic                     add_sub;
    logic                     bad_opcode;
    logic                     bad_funct7;
    logic                     bad_index;

    assign opcode = rv32i_types_pkg::opcode_t'(instr_i[6:0]);
    assign funct3 = rv32i_types_pkg::funct3_t'(instr_i[14:12]);
    assign funct7 = instr_i[31:25];

    assign is_regreg = (opcode == rv32i_types_pkg::REGREG);
    assign is_immed  = (opcode == rv32i_types_pkg::IMMED);

    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    // U immediate for LUI and AUIPC, sign-extended I immediate otherwise
    assign imm_o = (opcode == rv32i_types_pkg::LUI || opcode == rv32i_types_pkg::AUIPC) ?
                   {instr_i[31:12], 12'b0} : {{20{instr_i[31]}}, instr_i[31:20]};

    // A is the PC for AUIPC, B is the immediate unless register-register
    assign alu_a_sel_o = (opcode == rv32i_types_pkg::AUIPC);
    assign alu_b_sel_o = !is_regreg;

    assign w_sel_o = (opcode == rv32i_types_pkg::LUI) ? rv32i_types_pkg::W_SEL_FROM_IMM_U :
                                                         rv32i_types_pkg::W_SEL_FROM_ALU;

    always_comb begin
        case (opcode)
            rv32i_types_pkg::REGREG, rv32i_types_pkg::IMMED,
            rv32i_types_pkg::LUI, rv32i_types_pkg::AUIPC: bad_opcode = 1'b0;
            default:                                     bad_opcode = 1'b1;
        endcase
    end
    assign wen_o = !bad_opcode;

    // Bit 30 picks SUB for register ADD and SRA for either shift form
    assign sr      = (is_regreg || is_immed) && funct3 == rv32i_types_pkg::SR;
    assign add_sub = (is_regreg || is_immed) && funct3 == rv32i_types_pkg::ADDSUB;

    always_comb begin
        if ((is_regreg || is_immed) && funct3 == rv32i_types_pkg::SLL) begin
            alu_op_o = rv32i_types_pkg::ALU_SLL;
        end else if (sr && instr_i[30]) begin
            alu_op_o = rv32i_types_pkg::ALU_SRA;
        end else if (sr) begin
            alu_op_o = rv32i_types_pkg::ALU_SRL;
        end else if (add_sub && is_regreg && instr_i[30]) begin
            alu_op_o = rv32i_types_pkg::ALU_SUB;
        end else if (add_sub || opcode == rv32i_types_pkg::AUIPC) begin
            alu_op_o = rv32i_types_pkg::ALU_ADD;
        end else if ((is_regreg || is_immed) && funct3 == rv32i_types_pkg::AND) begin
            alu_op_o = rv32i_types_pkg::ALU_AND;
        end else if ((is_regreg || is_immed) && funct3 == rv32i_types_pkg::OR) begin
            alu_op_o = rv32i_types_pkg::ALU_OR;
        end else if ((is_regreg || is_immed) && funct3 == rv32i_types_pkg::XOR) begin
            alu_op_o = rv32i_types_pkg::ALU_XOR;
        end else if ((is_regreg || is_immed) && funct3 == rv32i_types_pkg::SLT) begin
            alu_op_o = rv32i_types_pkg::ALU_SLT;
        end else if ((is_regreg || is_immed) && funct3 == rv32i_types_pkg::SLTU) begin
            alu_op_o = rv32i_types_pkg::ALU_SLTU;
        end else begin
            alu_op_o = rv32i_types_pkg::ALU_ADD;
        end
    end

    // Only 0x20 with ADD/SUB or the right shift is a valid alternate funct7
    assign bad_funct7 = is_regreg &&
                        !(funct7 == 7'h00 ||
                          (funct7 == 7'h20 && (funct3 == rv32i_types_pkg::ADDSUB ||
                                               funct3 == rv32i_types_pkg::SR)));

    // RV32E style check on every index the instruction touches
    assign bad_index = (int'(rd_o) >= NUM_REGS) ||
                       ((is_regreg || is_immed) && int'(rs1_o) >= NUM_REGS) ||
                       (is_regreg && int'(rs2_o) >= NUM_REGS);

    assign illegal_o = bad_opcode || bad_funct7 || bad_index;

endmodule

// File: hdl/alu.sv
// Integer ALU
`timescale 1ns/1ps

module alu (
    input  rv32i_types_pkg::word_t   rs1_data_i,
    input  rv32i_types_pkg::word_t   rs2_data_i,
    input  rv32i_types_pkg::word_t   pc_i,
    input  rv32i_types_pkg::word_t   imm_i,
    input  logic                     alu_a_sel_i,
    input  logic                     alu_b_sel_i,
    input  rv32i_types_pkg::alu_op_t alu_op_i,
    output rv32i_types_pkg::word_t   result_o
);
    rv32i_types_pkg::word_t op_a;
    rv32i_types_pkg::word_t op_b;
    logic [4:0]             shamt;

    assign op_a  = alu_a_sel_i ? pc_i : rs1_data_i;
    assign op_b  = alu_b_sel_i ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            rv32i_types_pkg::ALU_ADD:  result_o = op_a + op_b;
            rv32i_types_pkg::ALU_SUB:  result_o = op_a - op_b;
            rv32i_types_pkg::ALU_SLL:  result_o = op_a << shamt;
            rv32i_types_pkg::ALU_SRL:  result_o = op_a >> shamt;
            rv32i_types_pkg::ALU_SRA:  result_o = $signed(op_a) >>> shamt;
            rv32i_types_pkg::ALU_AND:  result_o = op_a & op_b;
            rv32i_types_pkg::ALU_OR:   result_o = op_a | op_b;
            rv32i_types_pkg::ALU_XOR:  result_o = op_a ^ op_b;
            // Set-less-than forms return 0 or 1
            rv32i_types_pkg::ALU_SLT:  result_o = {31'b0, $signed(op_a) < $signed(op_b)};
            rv32i_types_pkg::ALU_SLTU: result_o = {31'b0, op_a < op_b};
            default:                   result_o = op_a + op_b;
        endcase
    end

endmodule

// File: hdl/reg_file.sv
// Result stage and register file
`timescale 1ns/1ps

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  rv32i_types_pkg::reg_idx_t rs1_i,
    input  rv32i_types_pkg::reg_idx_t rs2_i,
    output rv32i_types_pkg::word_t    rs1_data_o,
    output rv32i_types_pkg::word_t    rs2_data_o,
    input  rv32i_types_pkg::reg_idx_t rd_i,
    input  logic                      wen_i,
    input  rv32i_types_pkg::w_sel_t   w_sel_i,
    input  rv32i_types_pkg::word_t    alu_result_i,
    input  rv32i_types_pkg::word_t    imm_i,
    input  rv32i_types_pkg::reg_idx_t host_idx_i,
    input  logic                      host_wen_i,
    input  rv32i_types_pkg::word_t    host_wdata_i,
    output rv32i_types_pkg::word_t    host_rdata_o
);
    rv32i_types_pkg::word_t regs [NUM_REGS];
    rv32i_types_pkg::word_t w_data;

    // x0 and indexes past the end read as zero
    function automatic rv32i_types_pkg::word_t read_port(input rv32i_types_pkg::reg_idx_t idx);
        rv32i_types_pkg::word_t value;
        value = '0;
        if (idx != '0 && int'(idx) < NUM_REGS) begin
            value = regs[idx];
        end
        return value;
    endfunction

    assign w_data = (w_sel_i == rv32i_types_pkg::W_SEL_FROM_IMM_U) ? imm_i : alu_result_i;

    always_comb begin
        rs1_data_o   = read_port(rs1_i);
        rs2_data_o   = read_port(rs2_i);
        host_rdata_o = read_port(host_idx_i);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen_i && rd_i != '0 && int'(rd_i) < NUM_REGS) begin
                regs[rd_i] <= w_data;
            end
            // Host writes only happen outside instruction issue
            if (host_wen_i && host_idx_i != '0 && int'(host_idx_i) < NUM_REGS) begin
                regs[host_idx_i] <= host_wdata_i;
            end
        end
    end

endmodule

// File: hdl/apb_slave_port.sv
// APB slave and issue control
`timescale 1ns/1ps

module apb_slave_port #(
    parameter int NUM_REGS = 32
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  apb_map_pkg::apb_addr_t    paddr_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  rv32i_types_pkg::word_t    pwdata_i,
    output rv32i_types_pkg::word_t    prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    output rv32i_types_pkg::instr_t   instr_o,
    output rv32i_types_pkg::word_t    pc_o,
    output logic                      exec_valid_o,
    input  logic                      illegal_i,
    output rv32i_types_pkg::reg_idx_t host_idx_o,
    output logic                      host_wen_o,
    output rv32i_types_pkg::word_t    host_wdata_o,
    input  rv32i_types_pkg::word_t    host_rdata_i
);
    apb_map_pkg::issue_state_t state_q;
    rv32i_types_pkg::instr_t   instr_q;
    rv32i_types_pkg::word_t    pc_q;
    logic                      illegal_q;
    logic [15:0]               count_q;
    rv32i_types_pkg::word_t    status_word;

    logic access;
    logic is_reg;
    logic reg_in_range;
    logic is_instr;
    logic is_pc;
    logic is_status;
    logic instr_wr;
    logic retire;
    logic err;

    assign access = psel_i && penable_i;

    // Register window covers the first 32 words
    assign is_reg       = (paddr_i[11:7] == apb_map_pkg::REGS_BASE[11:7]) &&
                          (paddr_i[1:0] == 2'b00);
    assign host_idx_o   = paddr_i[6:2];
    assign reg_in_range = int'(host_idx_o) < NUM_REGS;
    assign is_instr     = (paddr_i == apb_map_pkg::INSTR_ADDR);
    assign is_pc        = (paddr_i == apb_map_pkg::PC_ADDR);
    assign is_status    = (paddr_i == apb_map_pkg::STATUS_ADDR);

    assign instr_wr = access && pwrite_i && is_instr;
    // Instruction retires in its second access cycle
    assign retire   = instr_wr && (state_q == apb_map_pkg::ISSUE_EXEC);

    // One wait state for instruction writes only
    assign pready_o = access && (!instr_wr || state_q == apb_map_pkg::ISSUE_EXEC);

    always_comb begin
        if (instr_wr) begin
            err = illegal_i;
        end else if (is_reg) begin
            err = !reg_in_range;
        end else if (is_instr) begin
            err = 1'b1;
        end else if (is_pc) begin
            err = 1'b0;
        end else if (is_status) begin
            err = pwrite_i;
        end else begin
            err = 1'b1;
        end
    end
    assign pslverr_o = pready_o && err;

    // Status fields placed by the register map
    always_comb begin
        status_word = '0;
        status_word[apb_map_pkg::STATUS_ILLEGAL_BIT] = illegal_q;
        status_word[apb_map_pkg::STATUS_COUNT_MSB:apb_map_pkg::STATUS_COUNT_LSB] = count_q;
    end

    always_comb begin
        if (is_reg) begin
            prdata_o = host_rdata_i;
        end else if (is_pc) begin
            prdata_o = pc_q;
        end else if (is_status) begin
            prdata_o = status_word;
        end else begin
            prdata_o = '0;
        end
    end

    assign host_wen_o   = access && pwrite_i && is_reg && reg_in_range;
    assign host_wdata_o = pwdata_i;

    assign instr_o      = instr_q;
    assign pc_o         = pc_q;
    assign exec_valid_o = (state_q == apb_map_pkg::ISSUE_EXEC);

    // Latch the instruction word in the first access cycle
    always_ff @(posedge clk_i) begin
        if (instr_wr && state_q == apb_map_pkg::ISSUE_IDLE) begin
            instr_q <= pwdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= apb_map_pkg::ISSUE_IDLE;
            pc_q      <= '0;
            illegal_q <= 1'b0;
            count_q   <= '0;
        end else begin
            case (state_q)
                apb_map_pkg::ISSUE_IDLE: begin
                    if (instr_wr) begin
                        state_q <= apb_map_pkg::ISSUE_EXEC;
                    end
                end
                default: state_q <= apb_map_pkg::ISSUE_IDLE;
            endcase
            if (access && pwrite_i && is_pc) begin
                pc_q <= pwdata_i;
            end
            if (retire) begin
                illegal_q <= illegal_i;
                // Retired count wraps silently
                if (!illegal_i) begin
                    count_q <= count_q + 16'd1;
                end
            end
        end
    end

endmodule

// File: hdl/rv_exec_unit.sv
// RV32I execution block top level
`timescale 1ns/1ps

module rv_exec_unit #(
    parameter int NUM_REGS = 32
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  apb_map_pkg::apb_addr_t paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  rv32i_types_pkg::word_t pwdata_i,
    output rv32i_types_pkg::word_t prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o
);
    rv32i_types_pkg::instr_t   instr;
    rv32i_types_pkg::word_t    pc;
    logic                      exec_valid;
    logic                      illegal;
    rv32i_types_pkg::reg_idx_t host_idx;
    logic                      host_wen;
    rv32i_types_pkg::word_t    host_wdata;
    rv32i_types_pkg::word_t    host_rdata;
    rv32i_types_pkg::reg_idx_t rs1;
    rv32i_types_pkg::reg_idx_t rs2;
    rv32i_types_pkg::reg_idx_t rd;
    rv32i_types_pkg::word_t    imm;
    logic                      alu_a_sel;
    logic                      alu_b_sel;
    rv32i_types_pkg::alu_op_t  alu_op;
    rv32i_types_pkg::w_sel_t   w_sel;
    logic                      cu_wen;
    logic                      rf_wen;
    rv32i_types_pkg::word_t    rs1_data;
    rv32i_types_pkg::word_t    rs2_data;
    rv32i_types_pkg::word_t    alu_result;

    // Writeback only for a legal instruction being issued
    assign rf_wen = cu_wen && exec_valid && !illegal;

    apb_slave_port #(
        .NUM_REGS(NUM_REGS)
    ) apb_slave_port_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .instr_o     (instr),
        .pc_o        (pc),
        .exec_valid_o(exec_valid),
        .illegal_i   (illegal),
        .host_idx_o  (host_idx),
        .host_wen_o  (host_wen),
        .host_wdata_o(host_wdata),
        .host_rdata_i(host_rdata)
    );

    control_unit #(
        .NUM_REGS(NUM_REGS)
    ) control_unit_i (
        .instr_i    (instr),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .rd_o       (rd),
        .imm_o      (imm),
        .alu_a_sel_o(alu_a_sel),
        .alu_b_sel_o(alu_b_sel),
        .alu_op_o   (alu_op),
        .w_sel_o    (w_sel),
        .wen_o      (cu_wen),
        .illegal_o  (illegal)
    );

    alu alu_i (
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .pc_i       (pc),
        .imm_i      (imm),
        .alu_a_sel_i(alu_a_sel),
        .alu_b_sel_i(alu_b_sel),
        .alu_op_i   (alu_op),
        .result_o   (alu_result)
    );

    reg_file #(
        .NUM_REGS(NUM_REGS)
    ) reg_file_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .rd_i        (rd),
        .wen_i       (rf_wen),
        .w_sel_i     (w_sel),
        .alu_result_i(alu_result),
        .imm_i       (imm),
        .host_idx_i  (host_idx),
        .host_wen_i  (host_wen),
        .host_wdata_i(host_wdata),
        .host_rdata_o(host_rdata)
    );

endmodule

// File: tests/rv_exec_unit_assertions.sv
// APB and issue checks for the slave port
`timescale 1ns/1ps

module rv_exec_unit_assertions (
    input logic                      clk_i,
    input logic                      reset_i,
    input apb_map_pkg::apb_addr_t    paddr_i,
    input logic                      psel_i,
    input logic                      penable_i,
    input logic                      pwrite_i,
    input logic                      pready_o,
    input logic                      host_wen_o,
    input logic                      exec_valid_o,
    input apb_map_pkg::issue_state_t state_q
);
    logic instr_done;

    assign instr_done = pready_o && pwrite_i && (paddr_i == apb_map_pkg::INSTR_ADDR);

    // Ready only in an access phase entered from a setup phase
    assert property (@(posedge clk_i) disable iff (reset_i)
        pready_o |-> (psel_i && penable_i && $past(psel_i)))
        else $error("pready_o high outside an APB access phase");

    // Instruction completes in its single ISSUE_EXEC cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
        instr_done |-> (state_q == apb_map_pkg::ISSUE_EXEC) &&
                       ($past(state_q) == apb_map_pkg::ISSUE_IDLE))
        else $error("instruction write completed without exactly one ISSUE_EXEC cycle");

    // Host writes and writeback never share a cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
        !(host_wen_o && exec_valid_o))
        else $error("host register write during instruction issue");

endmodule

bind apb_slave_port rv_exec_unit_assertions rv_exec_unit_assertions_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pready_o    (pready_o),
    .host_wen_o  (host_wen_o),
    .exec_valid_o(exec_valid_o),
    .state_q     (state_q)
);

// File: tests/tb_rv_exec_unit.sv
// Execution block testbench
`timescale 1ns/1ps

module tb_rv_exec_unit;

    localparam int NUM_REGS       = 32;
    localparam int TIMEOUT_CYCLES = 4000;

    // RV32I major opcodes
    localparam logic [6:0] OP_REG   = 7'h33;
    localparam logic [6:0] OP_IMM   = 7'h13;
    localparam logic [6:0] OP_LUI   = 7'h37;
    localparam logic [6:0] OP_AUIPC = 7'h17;
    localparam logic [6:0] OP_STORE = 7'h23;

    logic        clk_i;
    logic        reset_i;
    logic [11:0] paddr_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;

    logic [31:0] model_regs [NUM_REGS];
    logic [31:0] model_pc;
    logic [31:0] rng_state;
    int          cycles;
    int          wait_cycles;
    int          legal_count;
    string       test_name;

    rv_exec_unit #(
        .NUM_REGS(NUM_REGS)
    ) rv_exec_unit_i (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .paddr_i  (paddr_i),
        .psel_i   (psel_i),
        .penable_i(penable_i),
        .pwrite_i (pwrite_i),
        .pwdata_i (pwdata_i),
        .prdata_o (prdata_o),
        .pready_o (pready_o),
        .pslverr_o(pslverr_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h",
                     test_name, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opcode, input logic [19:0] imm,
                                          input logic [4:0] rd);
        return {imm, rd, opcode};
    endfunction

    // Reference arithmetic where alt is instruction bit 30
    function automatic logic [31:0] model_alu(input logic [2:0] funct3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (funct3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] status_word(input logic illegal);
        return {16'(legal_count), 15'b0, illegal};
    endfunction

    function automatic logic [11:0] reg_addr(input int idx);
        return apb_map_pkg::REGS_BASE + 12'(4 * idx);
    endfunction

    // Setup phase, then access phase until pready_o
    task automatic apb_transfer(input logic [11:0] addr, input logic write,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk_i);
        paddr_i   <= addr;
        pwrite_i  <= write;
        pwdata_i  <= wdata;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge clk_i);
        penable_i <= 1'b1;
        wait_cycles = 0;
        @(negedge clk_i);
        while (!pready_o) begin
            wait_cycles++;
            @(negedge clk_i);
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_transfer(addr, 1'b1, data, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(addr, 1'b0, '0, data, err);
    endtask

    task automatic write_reg(input int idx, input logic [31:0] value);
        logic err;
        apb_write(reg_addr(idx), value, err);
        check_value($sformatf("x%0d write error", idx), 0, err);
        check_value("register write wait", 0, wait_cycles);
        if (idx != 0) begin
            model_regs[idx] = value;
        end
    endtask

    task automatic read_check(input string name, input logic [11:0] addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_value({name, " error"}, 0, err);
        check_value(name, expected, data);
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            read_check($sformatf("x%0d", i), reg_addr(i), model_regs[i]);
        end
    endtask

    // Instruction writes always take one wait state
    task automatic issue(input logic [31:0] instr, input logic exp_err);
        logic err;
        apb_write(apb_map_pkg::INSTR_ADDR, instr, err);
        check_value($sformatf("instr %08h wait", instr), 1, wait_cycles);
        check_value($sformatf("instr %08h error", instr), exp_err, err);
        if (!exp_err) begin
            legal_count++;
        end
    endtask

    task automatic exec_check(input string name, input logic [31:0] instr, input int rd,
                              input logic [31:0] expected);
        issue(instr, 1'b0);
        if (rd != 0) begin
            model_regs[rd] = expected;
        end
        read_check(name, reg_addr(rd), model_regs[rd]);
    endtask

    task automatic reset_and_register_access();
        test_name = "reset_regs";
        @(negedge clk_i);
        check_value("pready_o after reset", 0, pready_o);
        check_value("pslverr_o after reset", 0, pslverr_o);
        check_all_regs();
        read_check("pc", apb_map_pkg::PC_ADDR, 32'd0);
        read_check("status", apb_map_pkg::STATUS_ADDR, 32'd0);
        for (int i = 1; i < NUM_REGS; i++) begin
            write_reg(i, rand_word());
        end
        write_reg(0, 32'hdead_beef);
        check_all_regs();
    endtask

    task automatic regreg_operations();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        alt;
        test_name = "regreg";
        for (int op = 0; op < 10; op++) begin
            // Ops 8 and 9 are SUB and SRA
            f3  = (op < 8) ? 3'(op) : ((op == 8) ? 3'd0 : 3'd5);
            alt = (op >= 8);
            a   = rand_word();
            b   = rand_word();
            write_reg(1, a);
            write_reg(2, b);
            exec_check($sformatf("funct3 %0d alt %0d", f3, alt),
                       enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'(op + 3)),
                       op + 3, model_alu(f3, alt, a, b));
        end
        // Signs differ, so SLT and SLTU disagree
        write_reg(1, 32'hffff_fff0);
        write_reg(2, 32'h0000_0010);
        exec_check("slt negative", enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd20), 20, 32'd1);
        exec_check("sltu negative", enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd21), 21, 32'd0);
        exec_check("slt reversed", enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd22), 22, 32'd0);
        exec_check("sltu reversed", enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd23), 23, 32'd1);
    endtask

    task automatic immediate_and_upper();
        logic [31:0] a;
        logic [31:0] r;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        logic        err;
        test_name = "immediate";
        for (int f = 0; f < 9; f++) begin
            f3  = (f < 8) ? 3'(f) : 3'd5;
            alt = (f == 8);
            a   = rand_word();
            r   = rand_word();
            imm = r[11:0];
            // Shift amount in the low bits, bit 30 set for SRAI
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {alt ? 7'h20 : 7'h00, r[4:0]};
            end
            write_reg(1, a);
            exec_check($sformatf("funct3 %0d alt %0d", f3, alt),
                       enc_i(imm, 5'd1, f3, 5'(f + 10)), f + 10,
                       model_alu(f3, alt, a, {{20{imm[11]}}, imm}));
        end
        model_pc = rand_word();
        apb_write(apb_map_pkg::PC_ADDR, model_pc, err);
        check_value("pc write error", 0, err);
        read_check("pc", apb_map_pkg::PC_ADDR, model_pc);
        r = rand_word();
        exec_check("lui", enc_u(OP_LUI, r[19:0], 5'd25), 25, {r[19:0], 12'h000});
        exec_check("auipc", enc_u(OP_AUIPC, r[31:12], 5'd26), 26,
                   model_pc + {r[31:12], 12'h000});
        read_check("pc unchanged", apb_map_pkg::PC_ADDR, model_pc);
    endtask

    task automatic illegal_instructions();
        test_name = "illegal";
        issue({7'h00, 5'd2, 5'd1, 3'b010, 5'd5, OP_STORE}, 1'b1);
        read_check("status after store", apb_map_pkg::STATUS_ADDR, status_word(1'b1));
        issue(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd6), 1'b1);
        read_check("status after funct7", apb_map_pkg::STATUS_ADDR, status_word(1'b1));
        // ECALL
        issue(32'h0000_0073, 1'b1);
        read_check("status after ecall", apb_map_pkg::STATUS_ADDR, status_word(1'b1));
        check_all_regs();
        exec_check("addi after illegal", enc_i(12'h005, 5'd0, 3'd0, 5'd7), 7, 32'd5);
        read_check("status cleared", apb_map_pkg::STATUS_ADDR, status_word(1'b0));
    endtask

    task automatic status_and_bus_errors();
        logic [31:0] data;
        logic        err;
        test_name = "status_errors";
        read_check("retired count", apb_map_pkg::STATUS_ADDR, status_word(1'b0));
        apb_write(apb_map_pkg::STATUS_ADDR, 32'hffff_ffff, err);
        check_value("status write error", 1, err);
        read_check("status unchanged", apb_map_pkg::STATUS_ADDR, status_word(1'b0));
        apb_read(12'h0a0, data, err);
        check_value("unmapped read error", 1, err);
        apb_write(12'h400, rand_word(), err);
        check_value("unmapped write error", 1, err);
        apb_read(apb_map_pkg::INSTR_ADDR, data, err);
        check_value("instr read error", 1, err);
        apb_write(12'h006, rand_word(), err);
        check_value("misaligned register error", 1, err);
        check_all_regs();
    endtask

    initial begin
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        paddr_i     = '0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        pwdata_i    = '0;
        cycles      = 0;
        wait_cycles = 0;
        legal_count = 0;
        rng_state   = 32'h7fd9;
        model_pc    = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;
        reset_and_register_access();
        regreg_operations();
        immediate_and_upper();
        illegal_instructions();
        status_and_bus_errors();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: flist.f
hdl/rv32i_types_pkg.sv
hdl/apb_map_pkg.sv
hdl/control_unit.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/apb_slave_port.sv
hdl/rv_exec_unit.sv
tests/rv_exec_unit_assertions.sv
tests/tb_rv_exec_unit.sv
